/* rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    localparam int xlen_w = 32;
    localparam logic [xlen_w-1:0] reset_pc = 32'h80000000;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add    = 3'b000;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;

    localparam logic [31:0] ebreak_word = 32'h00100073;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // j immediate is scrambled across the upper bits
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        exec_nop,
        exec_lui,
        exec_auipc,
        exec_jal,
        exec_jalr,
        exec_addi,
        exec_add,
        exec_lw,
        exec_lbu,
        exec_sw
    } exec_op_e;

endpackage

`default_nettype wire

/* exec_ctrl_if.sv */
`default_nettype none

// decoded control, one instruction per cycle
interface exec_ctrl_if
    import rv_core_pkg::*;
();

    exec_op_e          op;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    logic [xlen_w-1:0] imm;
    logic              reg_wen;

    modport decode (
        output op,
        output rs1,
        output rs2,
        output rd,
        output imm,
        output reg_wen
    );

    modport exec (
        input op,
        input imm
    );

    modport lsu (
        input op
    );

endinterface

`default_nettype wire

/* fetch_unit.sv */
`default_nettype none

module fetch_unit
    import rv_core_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              take_jump,
    input  logic [xlen_w-1:0] jump_target,
    input  logic              is_ebreak,
    output logic [xlen_w-1:0] pc,
    output logic              active,
    output logic              halted
);

    logic [xlen_w-1:0] next_pc;

    // sequential flow unless a jump is taken
    always_comb begin
        if (take_jump) begin
            next_pc = jump_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else if (!halted) begin
            // pc stays on the ebreak itself
            if (is_ebreak) begin
                halted <= 1'b1;
            end else begin
                pc <= next_pc;
            end
        end
    end

    // nothing commits while in reset or after ebreak
    assign active = !reset && !halted;

endmodule

`default_nettype wire

/* inst_decoder.sv */
`default_nettype none

module inst_decoder
    import rv_core_pkg::*;
(
    input  logic [xlen_w-1:0] inst,
    input  logic              active,
    exec_ctrl_if.decode       ctrl,
    output logic              take_jump,
    output logic              is_ebreak
);

    inst_u             word;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              is_r;
    logic              is_i;
    logic              is_s;
    logic              is_u;
    logic              is_j;
    logic [xlen_w-1:0] imm;
    exec_op_e          dec_op;
    logic              writes_rd;

    assign word   = inst;
    assign opcode = word.r_fmt.opcode;
    assign funct3 = word.i_fmt.funct3;

    // format class from the opcode alone
    always_comb begin
        is_r = 1'b0;
        is_i = 1'b0;
        is_s = 1'b0;
        is_u = 1'b0;
        is_j = 1'b0;
        case (opcode)
            op_imm, op_load, op_jalr, op_system: is_i = 1'b1;
            op_reg:                              is_r = 1'b1;
            op_store:                            is_s = 1'b1;
            op_lui, op_auipc:                    is_u = 1'b1;
            op_jal:                              is_j = 1'b1;
            default:                             is_r = 1'b0;
        endcase
    end

    // sign-extended immediate of the matching format
    always_comb begin
        imm = '0;
        if (is_i) begin
            imm = {{20{word.i_fmt.imm[11]}}, word.i_fmt.imm};
        end else if (is_s) begin
            imm = {{20{word.s_fmt.imm_11_5[6]}}, word.s_fmt.imm_11_5, word.s_fmt.imm_4_0};
        end else if (is_u) begin
            imm = {word.u_fmt.imm_31_12, 12'd0};
        end else if (is_j) begin
            imm = {{11{word.j_fmt.imm_20}}, word.j_fmt.imm_20, word.j_fmt.imm_19_12,
                   word.j_fmt.imm_11, word.j_fmt.imm_10_1, 1'b0};
        end
    end

    // anything outside the subset falls through as nop
    always_comb begin
        dec_op = exec_nop;
        case (opcode)
            op_lui:   dec_op = exec_lui;
            op_auipc: dec_op = exec_auipc;
            op_jal:   dec_op = exec_jal;
            op_jalr:  if (funct3 == f3_add) dec_op = exec_jalr;
            op_imm:   if (funct3 == f3_add) dec_op = exec_addi;
            op_reg: begin
                if (funct3 == f3_add && word.r_fmt.funct7 == 7'd0) begin
                    dec_op = exec_add;
                end
            end
            op_load: begin
                if (funct3 == f3_word) begin
                    dec_op = exec_lw;
                end else if (funct3 == f3_byte_u) begin
                    dec_op = exec_lbu;
                end
            end
            op_store: if (funct3 == f3_word) dec_op = exec_sw;
            default:  dec_op = exec_nop;
        endcase
    end

    assign writes_rd = (dec_op != exec_nop) && (dec_op != exec_sw);

    // x0 writes never reach the register file
    assign ctrl.op      = active ? dec_op : exec_nop;
    assign ctrl.reg_wen = active && writes_rd && (word.r_fmt.rd != 5'd0);
    assign ctrl.rd      = active ? word.r_fmt.rd : 5'd0;
    assign ctrl.rs1     = (active && !is_u && !is_j) ? word.r_fmt.rs1 : 5'd0;
    assign ctrl.rs2     = (active && (is_r || is_s)) ? word.r_fmt.rs2 : 5'd0;
    assign ctrl.imm     = active ? imm : '0;

    assign take_jump = active && (dec_op == exec_jal || dec_op == exec_jalr);
    assign is_ebreak = active && (inst == ebreak_word);

endmodule

`default_nettype wire

/* register_file.sv */
`default_nettype none

module register_file
    import rv_core_pkg::*;
(
    input  logic              clk,
    input  logic              wen,
    input  logic [4:0]        waddr,
    input  logic [4:0]        raddr1,
    input  logic [4:0]        raddr2,
    input  logic [xlen_w-1:0] wdata,
    output logic [xlen_w-1:0] rdata1,
    output logic [xlen_w-1:0] rdata2
);

    logic [xlen_w-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never stored, so force zero on read
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* exec_alu.sv */
`default_nettype none

module exec_alu
    import rv_core_pkg::*;
(
    exec_ctrl_if.exec         ctrl,
    input  logic [xlen_w-1:0] pc,
    input  logic [xlen_w-1:0] src1,
    input  logic [xlen_w-1:0] src2,
    output logic [xlen_w-1:0] alu_result,
    output logic [xlen_w-1:0] jump_target
);

    logic [xlen_w-1:0] pc_plus_imm;
    logic [xlen_w-1:0] src1_plus_imm;
    logic [xlen_w-1:0] link;

    assign pc_plus_imm   = pc + ctrl.imm;
    assign src1_plus_imm = src1 + ctrl.imm;
    assign link          = pc + 32'd4;

    always_comb begin
        case (ctrl.op)
            exec_lui:   alu_result = ctrl.imm;
            exec_auipc: alu_result = pc_plus_imm;
            exec_jal,
            exec_jalr:  alu_result = link;
            exec_addi:  alu_result = src1_plus_imm;
            exec_add:   alu_result = src1 + src2;
            // effective address for memory ops
            exec_lw,
            exec_lbu,
            exec_sw:    alu_result = src1_plus_imm;
            default:    alu_result = '0;
        endcase
    end

    // jalr drops bit 0 of the sum
    assign jump_target = (ctrl.op == exec_jal) ? pc_plus_imm
                                               : {src1_plus_imm[xlen_w-1:1], 1'b0};

endmodule

`default_nettype wire

/* load_store_unit.sv */
`default_nettype none

module load_store_unit
    import rv_core_pkg::*;
(
    exec_ctrl_if.lsu          ctrl,
    input  logic [xlen_w-1:0] alu_result,
    input  logic [xlen_w-1:0] store_data,
    output logic [xlen_w-1:0] dmem_addr,
    output logic [xlen_w-1:0] dmem_wdata,
    output logic              dmem_wen,
    output logic              dmem_ren,
    input  logic [xlen_w-1:0] dmem_rdata,
    output logic [xlen_w-1:0] wb_data
);

    logic [7:0] load_byte;

    // memory is word addressed, byte lane picked here
    assign dmem_addr  = {alu_result[xlen_w-1:2], 2'b00};
    assign dmem_wdata = store_data;
    assign dmem_wen   = (ctrl.op == exec_sw);
    assign dmem_ren   = (ctrl.op == exec_lw) || (ctrl.op == exec_lbu);

    always_comb begin
        case (alu_result[1:0])
            2'd0:    load_byte = dmem_rdata[7:0];
            2'd1:    load_byte = dmem_rdata[15:8];
            2'd2:    load_byte = dmem_rdata[23:16];
            default: load_byte = dmem_rdata[31:24];
        endcase
    end

    always_comb begin
        case (ctrl.op)
            exec_lw:  wb_data = dmem_rdata;
            exec_lbu: wb_data = {24'd0, load_byte};
            default:  wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

/* rv_core_top.sv */
`default_nettype none

module rv_core_top
    import rv_core_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // instruction port, combinational read
    output logic [xlen_w-1:0] imem_addr,
    input  logic [xlen_w-1:0] imem_data,

    // data port
    output logic [xlen_w-1:0] dmem_addr,
    output logic [xlen_w-1:0] dmem_wdata,
    output logic              dmem_wen,
    output logic              dmem_ren,
    input  logic [xlen_w-1:0] dmem_rdata,

    output logic [xlen_w-1:0] pc,
    output logic              halted,

    // register write of the retiring instruction
    output logic              retire_valid,
    output logic [4:0]        retire_rd,
    output logic [xlen_w-1:0] retire_data
);

    logic              active;
    logic              take_jump;
    logic              is_ebreak;
    logic [xlen_w-1:0] jump_target;
    logic [xlen_w-1:0] src1;
    logic [xlen_w-1:0] src2;
    logic [xlen_w-1:0] alu_result;
    logic [xlen_w-1:0] wb_data;

    exec_ctrl_if ctrl ();

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .take_jump   (take_jump),
        .jump_target (jump_target),
        .is_ebreak   (is_ebreak),
        .pc          (pc),
        .active      (active),
        .halted      (halted)
    );

    inst_decoder u_decoder (
        .inst      (imem_data),
        .active    (active),
        .ctrl      (ctrl.decode),
        .take_jump (take_jump),
        .is_ebreak (is_ebreak)
    );

    register_file u_regfile (
        .clk    (clk),
        .wen    (ctrl.reg_wen),
        .waddr  (ctrl.rd),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .wdata  (wb_data),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    exec_alu u_alu (
        .ctrl        (ctrl.exec),
        .pc          (pc),
        .src1        (src1),
        .src2        (src2),
        .alu_result  (alu_result),
        .jump_target (jump_target)
    );

    load_store_unit u_lsu (
        .ctrl       (ctrl.lsu),
        .alu_result (alu_result),
        .store_data (src2),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wen   (dmem_wen),
        .dmem_ren   (dmem_ren),
        .dmem_rdata (dmem_rdata),
        .wb_data    (wb_data)
    );

    assign imem_addr    = pc;
    assign retire_valid = active && ctrl.reg_wen;
    assign retire_rd    = ctrl.rd;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`default_nettype none

module tb_rv_core
    import rv_core_pkg::*;
();

    logic              clk = 1'b0;
    logic              reset;
    logic [xlen_w-1:0] imem_addr;
    logic [xlen_w-1:0] imem_data;
    logic [xlen_w-1:0] dmem_addr;
    logic [xlen_w-1:0] dmem_wdata;
    logic              dmem_wen;
    logic              dmem_ren;
    logic [xlen_w-1:0] dmem_rdata;
    logic [xlen_w-1:0] pc;
    logic              halted;
    logic              retire_valid;
    logic [4:0]        retire_rd;
    logic [xlen_w-1:0] retire_data;

    integer            seed;
    integer            retired;
    logic [31:0]       imem [logic [31:0]];
    logic [31:0]       dmem [logic [31:0]];
    logic [31:0]       model_x [32];
    logic [31:0]       model_pc;

    rv_core_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_wen     (dmem_wen),
        .dmem_ren     (dmem_ren),
        .dmem_rdata   (dmem_rdata),
        .pc           (pc),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        inst_u w;
        w = '0;
        w.i_fmt.opcode = opc;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = rd;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.imm    = imm;
        return w;
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        inst_u w;
        w = '0;
        w.u_fmt.opcode    = opc;
        w.u_fmt.rd        = rd;
        w.u_fmt.imm_31_12 = imm;
        return w;
    endfunction

    // x1 and x2 keep the data base, so random writes go elsewhere
    function automatic logic [4:0] pick_rd();
        logic [4:0] r;
        r = 5'(rand_below(6));
        return (r == 5'd0) ? 5'd0 : r + 5'd2;
    endfunction

    function automatic logic [31:0] gen_inst();
        inst_u       w;
        logic [31:0] off;
        logic [4:0]  rd;
        if (rand_below(60) == 0) begin
            return ebreak_word;
        end
        w  = '0;
        rd = pick_rd();
        case (rand_below(10))
            0: w = enc_u(op_lui, rd, 20'(rand_below(1 << 20)));
            1: w = enc_u(op_auipc, rd, 20'(rand_below(1 << 20)));
            2: begin
                // short hop either way, never onto itself
                off = (rand_below(32) - 16) * 4;
                if (off == 32'd0) begin
                    off = 32'd8;
                end
                w.j_fmt.opcode    = op_jal;
                w.j_fmt.rd        = rd;
                w.j_fmt.imm_20    = off[20];
                w.j_fmt.imm_19_12 = off[19:12];
                w.j_fmt.imm_11    = off[11];
                w.j_fmt.imm_10_1  = off[10:1];
            end
            3: w = enc_i(op_jalr, f3_add, rd, 5'(rand_below(8)), 12'(rand_below(16)));
            4, 5: w = enc_i(op_imm, f3_add, rd, 5'(rand_below(8)), 12'(rand_below(4096)));
            6: begin
                w.r_fmt.opcode = op_reg;
                w.r_fmt.funct3 = f3_add;
                w.r_fmt.rd     = rd;
                w.r_fmt.rs1    = 5'(rand_below(8));
                w.r_fmt.rs2    = 5'(rand_below(8));
            end
            7: begin
                if (rand_below(2) == 0) begin
                    w = enc_i(op_load, f3_word, rd, 5'(1 + rand_below(2)),
                              12'(rand_below(64) * 4));
                end else begin
                    w = enc_i(op_load, f3_byte_u, rd, 5'(1 + rand_below(2)),
                              12'(rand_below(256)));
                end
            end
            8: begin
                off = rand_below(64) * 4;
                w.s_fmt.opcode   = op_store;
                w.s_fmt.funct3   = f3_word;
                w.s_fmt.rs1      = 5'(1 + rand_below(2));
                w.s_fmt.rs2      = 5'(rand_below(8));
                w.s_fmt.imm_11_5 = off[11:5];
                w.s_fmt.imm_4_0  = off[4:0];
            end
            // shift and logic immediates fall outside the subset
            default: w = enc_i(op_imm, 3'(1 + rand_below(7)), rd, 5'(rand_below(8)),
                               12'(rand_below(4096)));
        endcase
        return w;
    endfunction

    function automatic logic [31:0] read_data(input logic [31:0] addr);
        if (dmem.exists(addr)) begin
            return dmem[addr];
        end
        return {addr[15:0], addr[31:16]} ^ 32'h6b1dc35a;
    endfunction

    task automatic check_retire(input exec_op_e op, input logic exp_valid,
                                input logic [4:0] exp_rd, input logic [31:0] exp_data);
        if (retire_valid !== exp_valid) begin
            abort_run($sformatf("error at %0t: op %0d retire_valid %b, expected %b",
                                $time, op, retire_valid, exp_valid));
        end else if (exp_valid && (retire_rd !== exp_rd || retire_data !== exp_data)) begin
            abort_run($sformatf("error at %0t: op %0d retired x%0d=%h, expected x%0d=%h",
                                $time, op, retire_rd, retire_data, exp_rd, exp_data));
        end
    endtask

    task automatic check_store(input exec_op_e op, input logic exp_wen, input logic exp_ren,
                               input logic [31:0] exp_addr, input logic [31:0] exp_data);
        if (dmem_wen !== exp_wen || dmem_ren !== exp_ren) begin
            abort_run($sformatf("error at %0t: op %0d strobes wen %b ren %b, expected %b %b",
                                $time, op, dmem_wen, dmem_ren, exp_wen, exp_ren));
        end else if ((exp_wen || exp_ren) && dmem_addr !== exp_addr) begin
            abort_run($sformatf("error at %0t: op %0d dmem_addr %h, expected %h",
                                $time, op, dmem_addr, exp_addr));
        end else if (exp_wen && dmem_wdata !== exp_data) begin
            abort_run($sformatf("error at %0t: op %0d dmem_wdata %h, expected %h",
                                $time, op, dmem_wdata, exp_data));
        end
    endtask

    task automatic check_pc(input logic [31:0] exp_pc, input logic exp_halted);
        if (pc !== exp_pc || halted !== exp_halted) begin
            abort_run($sformatf("error at %0t: pc %h halted %b, expected %h %b",
                                $time, pc, halted, exp_pc, exp_halted));
        end else if (imem_addr !== exp_pc) begin
            abort_run($sformatf("error at %0t: imem_addr %h, expected %h",
                                $time, imem_addr, exp_pc));
        end
    endtask

    initial begin
        inst_u       w;
        exec_op_e    op;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] ea;
        logic [31:0] res;
        logic [31:0] nxt;
        logic [31:0] ld;
        logic [31:0] probe_lw;
        logic [31:0] probe_sw;
        logic        wr;
        logic        halt_seen;
        integer      cycles;
        integer      i;
        seed       = 32'ha8ea;
        // words that would strobe and retire if the core were not gated
        probe_lw = enc_i(op_load, f3_word, 5'd3, 5'd1, 12'd0);
        w = '0;
        w.s_fmt.opcode = op_store;
        w.s_fmt.funct3 = f3_word;
        w.s_fmt.rs1    = 5'd1;
        w.s_fmt.rs2    = 5'd3;
        probe_sw = w;
        reset      = 1'b1;
        imem_data  = probe_lw;
        dmem_rdata = '0;
        retired    = 0;
        model_pc   = reset_pc;
        for (i = 0; i < 32; i++) begin
            model_x[i] = '0;
        end
        // data base 0x10000000 in x1 and x2, then known values in x3..x7
        imem[reset_pc]     = enc_u(op_lui, 5'd1, 20'h10000);
        imem[reset_pc + 4] = enc_u(op_lui, 5'd2, 20'h10000);
        for (i = 3; i < 8; i++) begin
            imem[reset_pc + 4 * i - 4] = enc_i(op_imm, f3_add, 5'(i), 5'd0,
                                               12'(rand_below(4096)));
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_pc(reset_pc, 1'b0);
        check_store(exec_nop, 1'b0, 1'b0, '0, '0);
        check_retire(exec_nop, 1'b0, 5'd0, '0);
        @(posedge clk);
        #2;
        reset = 1'b0;

        halt_seen = 1'b0;
        cycles    = 0;
        while (!halt_seen) begin
            if (cycles == 2000) begin
                abort_run("program did not reach ebreak within 2000 cycles");
            end
            cycles++;
            if (retired >= 400) begin
                imem[imem_addr] = ebreak_word;
            end else if (!imem.exists(imem_addr)) begin
                imem[imem_addr] = gen_inst();
            end
            imem_data = imem[imem_addr];
            #2;
            dmem_rdata = read_data(dmem_addr);
            @(negedge clk);

            check_pc(model_pc, 1'b0);
            w   = imem[model_pc];
            s1  = (w.r_fmt.rs1 == 5'd0) ? '0 : model_x[w.r_fmt.rs1];
            s2  = (w.r_fmt.rs2 == 5'd0) ? '0 : model_x[w.r_fmt.rs2];
            ea  = s1 + {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
            op  = exec_nop;
            res = '0;
            nxt = model_pc + 32'd4;
            case (w.r_fmt.opcode)
                op_lui: begin
                    op  = exec_lui;
                    res = {w.u_fmt.imm_31_12, 12'd0};
                end
                op_auipc: begin
                    op  = exec_auipc;
                    res = model_pc + {w.u_fmt.imm_31_12, 12'd0};
                end
                op_jal: begin
                    op  = exec_jal;
                    res = model_pc + 32'd4;
                    nxt = model_pc + {{11{w.j_fmt.imm_20}}, w.j_fmt.imm_20,
                                      w.j_fmt.imm_19_12, w.j_fmt.imm_11,
                                      w.j_fmt.imm_10_1, 1'b0};
                end
                op_jalr: begin
                    if (w.i_fmt.funct3 == f3_add) begin
                        op  = exec_jalr;
                        res = model_pc + 32'd4;
                        nxt = ea & ~32'd1;
                    end
                end
                op_imm: begin
                    if (w.i_fmt.funct3 == f3_add) begin
                        op  = exec_addi;
                        res = ea;
                    end
                end
                op_reg: begin
                    if (w.r_fmt.funct3 == f3_add && w.r_fmt.funct7 == 7'd0) begin
                        op  = exec_add;
                        res = s1 + s2;
                    end
                end
                op_load: begin
                    ld = read_data(ea & ~32'd3);
                    if (w.i_fmt.funct3 == f3_word) begin
                        op  = exec_lw;
                        res = ld;
                    end else if (w.i_fmt.funct3 == f3_byte_u) begin
                        op  = exec_lbu;
                        ld  = ld >> {ea[1:0], 3'b000};
                        res = {24'd0, ld[7:0]};
                    end
                end
                op_store: begin
                    if (w.s_fmt.funct3 == f3_word) begin
                        op = exec_sw;
                        ea = s1 + {{20{w.s_fmt.imm_11_5[6]}}, w.s_fmt.imm_11_5,
                                   w.s_fmt.imm_4_0};
                    end
                end
                default: ;
            endcase
            halt_seen = (w == ebreak_word);
            if (halt_seen) begin
                nxt = model_pc;
            end
            wr = (op != exec_nop) && (op != exec_sw) && (w.r_fmt.rd != 5'd0);

            check_retire(op, wr, w.r_fmt.rd, res);
            check_store(op, op == exec_sw, op == exec_lw || op == exec_lbu,
                        ea & ~32'd3, s2);
            if (wr) begin
                model_x[w.r_fmt.rd] = res;
            end
            if (op == exec_sw) begin
                dmem[ea & ~32'd3] = s2;
            end
            model_pc = nxt;
            retired++;
            @(posedge clk);
            #2;
        end

        cycles = 0;
        while (!halted) begin
            if (cycles == 2000) begin
                abort_run("halted did not rise within 2000 cycles after ebreak");
            end
            cycles++;
            @(posedge clk);
            #2;
        end
        // core must stay frozen on the ebreak even with live words on the bus
        for (i = 0; i < 20; i++) begin
            @(posedge clk);
            #2;
            imem_data = (i % 2 == 0) ? probe_sw : probe_lw;
            @(negedge clk);
            check_pc(model_pc, 1'b1);
            check_store(exec_nop, 1'b0, 1'b0, '0, '0);
            check_retire(exec_nop, 1'b0, 5'd0, '0);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
rv_core_pkg.sv
exec_ctrl_if.sv
fetch_unit.sv
inst_decoder.sv
register_file.sv
exec_alu.sv
load_store_unit.sv
rv_core_top.sv
tb_rv_core.sv
